// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/100ps --top-module alu_tb -f compile.f -Mdir obj_dir
	./obj_dir/Valu_tb

clean:
	rm -rf obj_dir

// ==== alu/alu_adder.sv ====
// ALU adder
// one shared 64-bit adder for add/sub at 64 and 32 bits, with c, o, a, s, z, p
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module alu_adder import alu_flag_pkg::*, alu_op_pkg::*; (
  input  alu_op_e op,
  input  data_t   a,
  input  data_t   b,
  output data_t   sum,
  output flags_t  flags
);

  localparam int W = `ALU_DATA_W;
  localparam int H = `ALU_HALF_W;

  logic         is_sub;
  logic         is32;
  data_t        b_eff;
  logic [W:0]   raw;
  logic         cy4;     // carry into bit 4
  logic         cy_h;    // carry into bit 32
  logic         cy_h_in; // carry into bit 31
  logic         cy_w_in; // carry into bit 63
  logic         cy_w;
  logic         carry;
  logic         ovf;

  assign is_sub = (op == op_sub64) || (op == op_sub32);
  assign is32   = (op == op_add32) || (op == op_sub32);

  // subtract as a + ~b + 1
  assign b_eff = is_sub ? ~b : b;
  assign raw   = {1'b0, a} + {1'b0, b_eff} + {{W{1'b0}}, is_sub};

  assign cy4     = raw[4] ^ a[4] ^ b_eff[4];
  assign cy_h    = raw[H] ^ a[H] ^ b_eff[H];
  assign cy_h_in = raw[H-1] ^ a[H-1] ^ b_eff[H-1];
  assign cy_w_in = raw[W-1] ^ a[W-1] ^ b_eff[W-1];
  assign cy_w    = raw[W];

  assign carry = is32 ? cy_h : cy_w;
  assign ovf   = is32 ? (cy_h_in ^ cy_h) : (cy_w_in ^ cy_w);

  assign sum = is32 ? {{(W-H){1'b0}}, raw[H-1:0]} : raw[W-1:0];

  always_comb begin
    flags.c = carry ^ is_sub; // borrow on sub
    flags.o = ovf;
    flags.a = cy4 ^ is_sub;
    flags.s = is32 ? sum[H-1] : sum[W-1];
    flags.z = is32 ? (sum[H-1:0] == '0) : (sum == '0);
    flags.p = parity8(sum[7:0]);
  end

endmodule

`default_nettype wire

// ==== alu/alu_exec.sv ====
// ALU execute stage
// picks the adder or logic/move unit by opcode class, builds cmov, cset and
// lahf results, and applies the flag-write rule
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module alu_exec import alu_flag_pkg::*, alu_op_pkg::*; (
  input  req_t req,
  output res_t res
);

  data_t  sum;
  flags_t add_flags;
  data_t  lm_value;
  flags_t lm_flags;
  logic   taken;
  logic   is_arith;
  logic   is_logic;
  data_t  result;
  flags_t flags;
  logic   we;

  alu_adder u_add (.op(req.op), .a(req.a), .b(req.b), .sum(sum), .flags(add_flags));

  alu_logic_mov u_lm (.op(req.op), .a(req.a), .b(req.b), .value(lm_value), .flags(lm_flags));

  cond_eval u_cond (.flags(req.flags_in), .cond(req.cond), .taken(taken));

  assign is_arith = req.op inside {op_add64, op_add32, op_sub64, op_sub32};
  assign is_logic = req.op inside {op_and64, op_and32, op_or64, op_or32,
                                   op_xor64, op_xor32, op_xnor64, op_xnor32};

  always_comb begin
    result = lm_value; // moves and extensions by default
    flags  = lm_flags;
    we     = 1'b0;
    if (is_arith) begin
      result = sum;
      flags  = add_flags;
      we     = req.set_flags;
    end else if (is_logic) begin
      we = req.set_flags;
    end else if (req.op == op_cmov) begin
      result = taken ? req.b : req.a;
    end else if (req.op == op_cset) begin
      result = {{(`ALU_DATA_W-1){1'b0}}, taken};
    end else if (req.op == op_lahf) begin
      result = '0;
      flags  = flags_t'(req.a[`ALU_FLAG_W-1:0]);
      we     = 1'b1;
    end
  end

  // flags_out reads as zero when nothing is written
  assign res = '{result: result, flags_out: we ? flags : '0, flags_we: we};

endmodule

`default_nettype wire

// ==== alu/alu_logic_mov.sv ====
// ALU logic and move unit
// bitwise ops, moves and zero/sign extensions at the opcode width,
// plus s/z/p flags for the bitwise ops
`timescale 1ns/100ps
`default_nettype none
`include "alu_params.svh"

module alu_logic_mov import alu_flag_pkg::*, alu_op_pkg::*; (
  input  alu_op_e op,
  input  data_t   a,
  input  data_t   b,
  output data_t   value,
  output flags_t  flags
);

  localparam int W = `ALU_DATA_W;
  localparam int H = `ALU_HALF_W;

  data_t raw;
  logic  is32;

  assign is32 = op inside {op_and32, op_or32, op_xor32, op_xnor32, op_mov32};

  always_comb begin
    case (op)
      op_and64, op_and32:   raw = a & b;
      op_or64, op_or32:     raw = a | b;
      op_xor64, op_xor32:   raw = a ^ b;
      op_xnor64, op_xnor32: raw = ~(a ^ b);
      op_mov64, op_mov32:   raw = b;
      op_zxt8:              raw = {{(W-8){1'b0}}, b[7:0]};
      op_zxt16:             raw = {{(W-16){1'b0}}, b[15:0]};
      op_sxt8:              raw = {{(W-8){b[7]}}, b[7:0]};
      op_sxt16:             raw = {{(W-16){b[15]}}, b[15:0]};
      op_sxt32:             raw = {{(W-H){b[H-1]}}, b[H-1:0]};
      default:              raw = '0;
    endcase
  end

  // 32-bit forms clear the upper half
  assign value = is32 ? {{(W-H){1'b0}}, raw[H-1:0]} : raw;
  assign flags = logic_flags(value, is32);

endmodule

`default_nettype wire

// ==== alu/alu_top.sv ====
// ALU top level
// two-stage pipelined 64-bit ALU: request register, combinational execute,
// result register, valid/ready on both ends
`timescale 1ns/100ps
`default_nettype none

module alu_top import alu_flag_pkg::*, alu_op_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  output logic    in_ready,
  input  alu_op_e op,
  input  cond_e   cond,
  input  logic    set_flags,
  input  data_t   a,
  input  data_t   b,
  input  flags_t  flags_in,
  output logic    out_valid,
  input  logic    out_ready,
  output data_t   result,
  output flags_t  flags_out,
  output logic    flags_we
);

  req_t req_in;
  req_t req_q;
  res_t res_d;
  res_t res_q;
  logic req_valid;
  logic res_ready;

  assign req_in = '{op: op, cond: cond, set_flags: set_flags, a: a, b: b,
                    flags_in: flags_in};

  pipe_stage #(.payload_t(req_t)) u_req (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (req_in),
    .out_valid (req_valid),
    .out_ready (res_ready),
    .out_data  (req_q)
  );

  alu_exec u_exec (
    .req (req_q),
    .res (res_d)
  );

  pipe_stage #(.payload_t(res_t)) u_res (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (req_valid),
    .in_ready  (res_ready),
    .in_data   (res_d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (res_q)
  );

  assign result    = res_q.result;
  assign flags_out = res_q.flags_out;
  assign flags_we  = res_q.flags_we;

endmodule

`default_nettype wire

// ==== alu/cond_eval.sv ====
// Condition evaluator
// tests one of sixteen condition codes against a flag word, x86 style
`timescale 1ns/100ps
`default_nettype none

module cond_eval import alu_flag_pkg::*; (
  input  flags_t flags,
  input  cond_e  cond,
  output logic   taken
);

  logic sxo;

  assign sxo = flags.s ^ flags.o; // signed less-than

  always_comb begin
    case (cond)
      cond_z:      taken = flags.z;
      cond_nz:     taken = ~flags.z;
      cond_s:      taken = flags.s;
      cond_ns:     taken = ~flags.s;
      cond_ugt:    taken = ~flags.c & ~flags.z;
      cond_ule:    taken = flags.c | flags.z;
      cond_uge:    taken = ~flags.c;
      cond_ult:    taken = flags.c;
      cond_sgt:    taken = ~sxo & ~flags.z;
      cond_sle:    taken = sxo | flags.z;
      cond_sge:    taken = ~sxo;
      cond_slt:    taken = sxo;
      cond_o:      taken = flags.o;
      cond_no:     taken = ~flags.o;
      cond_p:      taken = flags.p;
      cond_always: taken = 1'b1;
      default:     taken = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== common/alu_flag_pkg.sv ====
// ALU flag package
// flag word layout, condition codes and the flag helpers used by the units
`default_nettype none
`include "alu_params.svh"

package alu_flag_pkg;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef enum logic [`ALU_COND_W-1:0] {
    cond_z, cond_nz, cond_s, cond_ns,
    cond_ugt, cond_ule, cond_uge, cond_ult,
    cond_sgt, cond_sle, cond_sge, cond_slt,
    cond_o, cond_no, cond_p, cond_always
  } cond_e;

  // even parity, set when the byte has an even count of ones
  function automatic logic parity8(input logic [7:0] v);
    return ~^v;
  endfunction

  function automatic flags_t logic_flags(input logic [`ALU_DATA_W-1:0] value, input logic is32);
    flags_t f;
    f = '0; // c, o, a stay clear for logic ops
    f.s = is32 ? value[`ALU_HALF_W-1] : value[`ALU_DATA_W-1];
    f.z = is32 ? (value[`ALU_HALF_W-1:0] == '0) : (value == '0);
    f.p = parity8(value[7:0]);
    return f;
  endfunction

endpackage

`default_nettype wire

// ==== common/alu_op_pkg.sv ====
// ALU operation package
// operand type, opcode set and the request/result payloads carried by the pipe
`default_nettype none
`include "alu_params.svh"

package alu_op_pkg;
  import alu_flag_pkg::*;

  typedef logic [`ALU_DATA_W-1:0] data_t;

  typedef enum logic [`ALU_OP_W-1:0] {
    op_add64, op_add32,
    op_sub64, op_sub32,
    op_and64, op_and32,
    op_or64, op_or32,
    op_xor64, op_xor32,
    op_xnor64, op_xnor32,
    op_mov64, op_mov32,
    op_zxt8, op_zxt16,
    op_sxt8, op_sxt16, op_sxt32,
    op_cmov,
    op_cset,
    op_lahf  // flag restore from a[5:0]
  } alu_op_e;

  // 144 bits
  typedef struct packed {
    alu_op_e op;
    cond_e   cond;
    logic    set_flags;
    data_t   a;
    data_t   b;
    flags_t  flags_in;
  } req_t;

  // 71 bits
  typedef struct packed {
    data_t  result;
    flags_t flags_out;
    logic   flags_we;
  } res_t;

endpackage

`default_nettype wire

// ==== common/alu_params.svh ====
// ALU width parameters
// operand, flag, opcode and condition widths shared by the packages and the RTL

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// operand and result width
`define ALU_DATA_W 64

// width of the 32-bit operation forms
`define ALU_HALF_W 32

`define ALU_FLAG_W 6
`define ALU_OP_W 5
`define ALU_COND_W 4

`endif

// ==== compile.f ====
+incdir+common
+incdir+dv
common/alu_flag_pkg.sv
common/alu_op_pkg.sv
hdl/pipe_stage.sv
alu/cond_eval.sv
alu/alu_adder.sv
alu/alu_logic_mov.sv
alu/alu_exec.sv
alu/alu_top.sv
dv/alu_tb.sv

// ==== dv/alu_ref_model.svh ====
// ALU reference model
// expected result, flags and flag write for one request, from the operation rules

`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// s, z and p over the operation width; c, o, a left clear
function automatic flags_t width_flags(input data_t r, input logic narrow);
  flags_t f;
  f = '0;
  f.s = narrow ? r[31] : r[63];
  f.z = narrow ? (r[31:0] == 32'd0) : (r == 64'd0);
  f.p = ~^r[7:0]; // even parity of low byte
  return f;
endfunction

function automatic void arith_model(input alu_op_e opc, input data_t x_in, input data_t y_in,
                                   output data_t r, output flags_t f);
  logic        sub;
  logic        narrow;
  data_t       x;
  data_t       y;
  logic [64:0] wide;
  logic        sx;
  logic        sy;
  sub    = opc inside {op_sub64, op_sub32};
  narrow = opc inside {op_add32, op_sub32};
  x      = narrow ? {32'd0, x_in[31:0]} : x_in;
  y      = narrow ? {32'd0, y_in[31:0]} : y_in;
  wide   = sub ? {1'b0, x} - {1'b0, y} : {1'b0, x} + {1'b0, y};
  r      = narrow ? {32'd0, wide[31:0]} : wide[63:0];
  f      = width_flags(r, narrow);
  sx     = narrow ? x[31] : x[63];
  sy     = narrow ? y[31] : y[63];
  f.c    = sub ? (x < y) : (narrow ? wide[32] : wide[64]); // borrow on sub
  f.a    = sub ? (x[3:0] < y[3:0]) : ({1'b0, x[3:0]} + {1'b0, y[3:0]} > 5'd15);
  f.o    = sub ? (sx != sy && f.s != sx) : (sx == sy && f.s != sx);
endfunction

function automatic data_t logic_model(input alu_op_e opc, input data_t x, input data_t y);
  data_t r;
  case (opc)
    op_and64, op_and32:   r = x & y;
    op_or64, op_or32:     r = x | y;
    op_xor64, op_xor32:   r = x ^ y;
    op_xnor64, op_xnor32: r = ~(x ^ y);
    op_mov64, op_mov32:   r = y;
    op_zxt8:              r = {56'd0, y[7:0]};
    op_zxt16:             r = {48'd0, y[15:0]};
    op_sxt8:              r = {{56{y[7]}}, y[7:0]};
    op_sxt16:             r = {{48{y[15]}}, y[15:0]};
    op_sxt32:             r = {{32{y[31]}}, y[31:0]};
    default:              r = '0;
  endcase
  if (opc inside {op_and32, op_or32, op_xor32, op_xnor32, op_mov32}) r[63:32] = '0;
  return r;
endfunction

function automatic logic cond_model(input flags_t f, input cond_e cc);
  logic lt;
  lt = f.s != f.o; // signed less-than
  case (cc)
    cond_z:   return f.z;
    cond_nz:  return !f.z;
    cond_s:   return f.s;
    cond_ns:  return !f.s;
    cond_ugt: return !(f.c || f.z);
    cond_ule: return f.c || f.z;
    cond_uge: return !f.c;
    cond_ult: return f.c;
    cond_sgt: return !(lt || f.z);
    cond_sle: return lt || f.z;
    cond_sge: return !lt;
    cond_slt: return lt;
    cond_o:   return f.o;
    cond_no:  return !f.o;
    cond_p:   return f.p;
    default:  return 1'b1;
  endcase
endfunction

function automatic res_t model_res(input alu_op_e opc, input cond_e cc, input logic sf,
                                   input data_t x, input data_t y, input flags_t fin);
  res_t   e;
  data_t  r;
  flags_t f;
  logic   bitwise;
  logic   narrow;
  e       = '0;
  bitwise = opc inside {op_and64, op_and32, op_or64, op_or32,
                        op_xor64, op_xor32, op_xnor64, op_xnor32};
  narrow  = opc inside {op_and32, op_or32, op_xor32, op_xnor32};
  case (opc)
    op_add64, op_add32, op_sub64, op_sub32: begin
      arith_model(opc, x, y, r, f);
      e = '{result: r, flags_out: f, flags_we: sf};
    end
    op_cmov: e.result = cond_model(fin, cc) ? y : x;
    op_cset: e.result = {63'd0, cond_model(fin, cc)};
    op_lahf: e = '{result: '0, flags_out: flags_t'(x[5:0]), flags_we: 1'b1};
    default: begin
      r = logic_model(opc, x, y);
      e = '{result: r, flags_out: width_flags(r, narrow), flags_we: sf & bitwise};
    end
  endcase
  if (!e.flags_we) e.flags_out = '0;
  return e;
endfunction

`endif

// ==== dv/alu_tb.sv ====
// ALU testbench
// random requests with stalls on both ends, checked in order against a model
`timescale 1ns/100ps
`default_nettype none

module alu_tb import alu_flag_pkg::*, alu_op_pkg::*; ();

  localparam int NUM_RESULTS = 2000;
  localparam int STREAM_N    = 16; // back-to-back items after reset
  localparam int CLK_NS      = 10;

  logic    clk = 1'b0;
  logic    rst;
  logic    in_valid;
  logic    in_ready;
  alu_op_e op;
  cond_e   cond;
  logic    set_flags;
  data_t   a;
  data_t   b;
  flags_t  flags_in;
  logic    out_valid;
  logic    out_ready;
  data_t   result;
  flags_t  flags_out;
  logic    flags_we;

  integer seed;
  res_t   exp_q[$];
  int     acc_q[$]; // acceptance cycle per item
  int     cycle;
  int     n_acc;
  int     n_done;
  int     n_extra;

  `include "alu_ref_model.svh"

  alu_top dut (.*);

  always #(CLK_NS / 2) clk = ~clk;

  task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input string name, input data_t got, input data_t want);
    if (got !== want) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
      fail_run();
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t want);
    if (got !== want) begin
      $display("mismatch at %0t: %s got %b expected %b (c o a s z p)", $time, name, got, want);
      fail_run();
    end
  endtask

  task automatic check_we(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, want);
      fail_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int want);
    if (got != want) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
      fail_run();
    end
  endtask

  function automatic int unsigned roll(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // edge values for carry, overflow and zero, else random
  function automatic data_t pick_operand();
    data_t v;
    case (roll(16))
      0: v = '0;
      1: v = 64'd1;
      2: v = '1;
      3: v = 64'h7fff_ffff_ffff_ffff;
      4: v = 64'h8000_0000_0000_0000;
      5: v = 64'h0000_0000_7fff_ffff;
      6: v = 64'h0000_0000_8000_0000;
      7: v = 64'h0000_0000_ffff_ffff;
      8: v = 64'h0000_0000_0000_000f;
      default: begin
        v[63:32] = $random(seed);
        v[31:0]  = $random(seed);
      end
    endcase
    return v;
  endfunction

  task automatic gen_request();
    op        = alu_op_e'(5'(roll(22)));
    cond      = cond_e'(4'(roll(16)));
    set_flags = roll(5) != 0;
    a         = pick_operand();
    b         = (roll(8) == 0) ? a : pick_operand();
    flags_in  = flags_t'(6'(roll(64)));
  endtask

  initial begin
    #(NUM_RESULTS * 8 * CLK_NS);
    $display("results stopped arriving, %0d of %0d checked", n_done, NUM_RESULTS);
    fail_run();
  end

  initial begin
    res_t got;
    res_t want;
    logic in_fire;
    logic out_fire;
    seed      = 32'h10cf_c7f3;
    rst       = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    op        = op_add64;
    cond      = cond_z;
    set_flags = 1'b0;
    a         = '0;
    b         = '0;
    flags_in  = '0;
    cycle     = 0;
    n_acc     = 0;
    n_done    = 0;
    n_extra   = 0;
    in_fire   = 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_we("out_valid", out_valid, 1'b0);
    end
    rst = 1'b0;
    @(negedge clk);
    check_we("out_valid", out_valid, 1'b0);
    check_we("in_ready", in_ready, 1'b1);
    while (n_done < NUM_RESULTS) begin
      if (n_acc >= NUM_RESULTS) begin
        in_valid = 1'b0;
      end else if (!in_valid || in_fire) begin
        in_valid = (n_acc < STREAM_N) || (roll(10) < 7);
        if (in_valid) gen_request();
      end
      out_ready = (n_done < STREAM_N) || (roll(4) != 0);
      #1; // snapshot once the inputs have settled
      in_fire  = in_valid & in_ready;
      out_fire = out_valid & out_ready;
      got      = '{result: result, flags_out: flags_out, flags_we: flags_we};
      if (in_valid && n_acc < STREAM_N) check_we("in_ready", in_ready, 1'b1);
      @(posedge clk);
      cycle++;
      if (out_fire) begin
        if (exp_q.size() == 0) begin
          $display("a result came out with no request outstanding at %0t", $time);
          fail_run();
        end
        want = exp_q.pop_front();
        check_result("result", got.result, want.result);
        check_flags("flags_out", got.flags_out, want.flags_out);
        check_we("flags_we", got.flags_we, want.flags_we);
        if (n_done < STREAM_N) check_count("latency", cycle - acc_q.pop_front(), 2);
        else void'(acc_q.pop_front());
        n_done++;
      end
      if (in_fire) begin
        exp_q.push_back(model_res(op, cond, set_flags, a, b, flags_in));
        acc_q.push_back(cycle);
        n_acc++;
      end
      @(negedge clk);
    end
    // pipe must stay empty once every request is answered
    out_ready = 1'b1;
    repeat (4) begin
      #1;
      if (out_valid) n_extra++;
      @(negedge clk);
    end
    if (n_extra != 0) begin
      $display("out_valid stayed high %0d cycles after the last expected result", n_extra);
      fail_run();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pipe_stage.sv ====
// Pipeline register stage
// one valid/ready slot holding a payload of any packed type
// accepts a new item in the same cycle the held one drains
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  logic     in_fire;
  payload_t data_q;

  assign in_ready  = ~full | out_ready; // room now or slot drains this cycle
  assign in_fire   = in_valid & in_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_fire) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) data_q <= in_data;
  end

endmodule

`default_nettype wire
